//--- rtl/isa_pkg.sv
`default_nettype none

package isa_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;

	// instruction field positions
	localparam int OPCODE_MSB = 31;
	localparam int OPCODE_LSB = 27;
	localparam int DEST_MSB = 26;
	localparam int DEST_LSB = 22;
	localparam int SRC1_MSB = 21;
	localparam int SRC1_LSB = 17;
	localparam int SRC2_MSB = 16;
	localparam int SRC2_LSB = 12;
	localparam int IMM_WIDTH = 16;

	// opcodes not listed here decode as bubbles
	typedef enum logic [4:0] {
		OP_ADD  = 5'b00000,
		OP_ADDI = 5'b00001,
		OP_SUB  = 5'b00010,
		OP_AND  = 5'b00011,
		OP_ANDI = 5'b00100,
		OP_OR   = 5'b00101,
		OP_ORI  = 5'b00110,
		OP_XOR  = 5'b00111,
		OP_SLL  = 5'b01000,
		OP_SRL  = 5'b01001,
		OP_SRA  = 5'b01010,
		OP_LLI  = 5'b01011,
		OP_LUI  = 5'b01100,
		OP_B    = 5'b10001,
		OP_BL   = 5'b10010,
		OP_RET  = 5'b10011
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA
	} alu_op_e;

	// top three bits of the dest field
	typedef enum logic [2:0] {
		COND_NE,
		COND_EQ,
		COND_GT,
		COND_LT,
		COND_GE,
		COND_LE,
		COND_OVERFLOW,
		COND_ALWAYS
	} branch_cond_e;

	typedef struct packed {
		logic zero;
		logic sign;
		logic overflow;
	} flags_t;

endpackage

`default_nettype wire

//--- rtl/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

	typedef enum logic [1:0] {
		WRITE_NONE,
		WRITE_FULL,
		WRITE_LOWER,
		WRITE_UPPER
	} write_kind_e;

	// register file write port, also the writeback stage contents
	typedef struct packed {
		write_kind_e write_kind;
		isa_pkg::reg_addr_t dest;
		isa_pkg::word_t data;
	} reg_write_t;

	// decode to execute
	typedef struct packed {
		isa_pkg::word_t operand1;
		isa_pkg::word_t operand2;
		isa_pkg::word_t immediate;
		isa_pkg::reg_addr_t source1;
		isa_pkg::reg_addr_t source2;
		isa_pkg::alu_op_e alu_op;
		logic use_immediate;
		logic select_immediate;
		logic update_flags;
		write_kind_e write_kind;
		isa_pkg::reg_addr_t dest;
	} ex_payload_t;

	// execute to writeback
	typedef reg_write_t wb_payload_t;

endpackage

`default_nettype wire

//--- rtl/fetch_unit.sv
`default_nettype none
`timescale 1ns/1ns

module fetch_unit #(
	parameter int INSTR_ADDR_WIDTH = 11
) (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire isa_pkg::word_t          instr,
	input  wire                          stall,
	input  wire                          branch_taken,
	input  wire [INSTR_ADDR_WIDTH-1:0]   branch_target,
	input  wire                          link_write,
	input  wire [INSTR_ADDR_WIDTH-1:0]   link_value,
	input  wire                          link_return,
	output logic [INSTR_ADDR_WIDTH-1:0]  instr_addr,
	output isa_pkg::word_t               fetched_instr,
	output logic [INSTR_ADDR_WIDTH-1:0]  fetched_pc,
	output logic                         fetched_bubble
);

	logic [INSTR_ADDR_WIDTH-1:0] link_reg;

	// link register for bl / ret
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			link_reg <= '0;
		end else if (link_write) begin
			link_reg <= link_value;
		end
	end

	// program counter, word addressed
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			instr_addr <= '0;
		end else if (branch_taken) begin
			instr_addr <= branch_target;
		end else if (link_return) begin
			instr_addr <= link_reg;
		end else if (!stall) begin
			instr_addr <= instr_addr + 1'b1;
		end
	end

	// fetch/decode register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fetched_instr <= '0;
			fetched_pc <= '0;
			fetched_bubble <= 1'b1;
		end else if (branch_taken || link_return) begin
			// drop the word fetched behind the redirect
			fetched_instr <= '0;
			fetched_pc <= instr_addr;
			fetched_bubble <= 1'b1;
		end else if (!stall) begin
			fetched_instr <= instr;
			fetched_pc <= instr_addr;
			fetched_bubble <= (instr == '0);
		end
	end

endmodule

`default_nettype wire

//--- rtl/decode_unit.sv
`default_nettype none
`timescale 1ns/1ns

module decode_unit #(
	parameter int INSTR_ADDR_WIDTH = 11
) (
	input  wire isa_pkg::word_t          fetched_instr,
	input  wire [INSTR_ADDR_WIDTH-1:0]   fetched_pc,
	input  wire                          fetched_bubble,
	input  wire isa_pkg::flags_t         flags,
	input  wire                          flag_update_pending,
	input  wire pipe_pkg::reg_write_t    pending_ex,
	input  wire pipe_pkg::reg_write_t    pending_wb,
	output isa_pkg::reg_addr_t           rf_addr1,
	output isa_pkg::reg_addr_t           rf_addr2,
	input  wire isa_pkg::word_t          rf_data1,
	input  wire isa_pkg::word_t          rf_data2,
	output pipe_pkg::ex_payload_t        payload,
	output logic                         payload_bubble,
	output logic                         stall,
	output logic                         branch_taken,
	output logic [INSTR_ADDR_WIDTH-1:0]  branch_target,
	output logic                         link_write,
	output logic [INSTR_ADDR_WIDTH-1:0]  link_value,
	output logic                         link_return
);

	import isa_pkg::*;
	import pipe_pkg::*;

	opcode_e opcode;
	branch_cond_e cond;
	word_t immediate;
	logic is_exec;
	logic reads_src1;
	logic reads_src2;
	logic is_branch;
	logic is_link;
	logic is_return;
	logic condition_met;
	logic hazard_read;
	logic hazard_branch;

	// true when a lower or upper write to this register is still in flight
	function automatic logic half_pending(reg_write_t pending, reg_addr_t addr);
		return (pending.write_kind == WRITE_LOWER || pending.write_kind == WRITE_UPPER)
			&& pending.dest == addr;
	endfunction

	assign opcode = opcode_e'(fetched_instr[OPCODE_MSB:OPCODE_LSB]);
	assign cond = branch_cond_e'(fetched_instr[DEST_MSB -: 3]);
	assign immediate = {{(32 - IMM_WIDTH){fetched_instr[IMM_WIDTH-1]}},
		fetched_instr[IMM_WIDTH-1:0]};

	assign rf_addr1 = fetched_instr[SRC1_MSB:SRC1_LSB];
	assign rf_addr2 = fetched_instr[SRC2_MSB:SRC2_LSB];

	////////////////////////////////////////////////////////////////////////////
	// opcode decode
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		payload = '0;
		payload.operand1 = rf_data1;
		payload.operand2 = rf_data2;
		payload.immediate = immediate;
		payload.source1 = rf_addr1;
		payload.source2 = rf_addr2;
		payload.dest = fetched_instr[DEST_MSB:DEST_LSB];
		is_exec = 1'b0;
		reads_src1 = 1'b0;
		reads_src2 = 1'b0;
		is_branch = 1'b0;
		is_link = 1'b0;
		is_return = 1'b0;

		case (opcode)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_SRA: begin
				payload.write_kind = WRITE_FULL;
				payload.update_flags = 1'b1;
				reads_src1 = 1'b1;
				reads_src2 = 1'b1;
				is_exec = 1'b1;
			end
			OP_ADDI, OP_ANDI, OP_ORI: begin
				payload.write_kind = WRITE_FULL;
				payload.update_flags = 1'b1;
				payload.use_immediate = 1'b1;
				reads_src1 = 1'b1;
				is_exec = 1'b1;
			end
			OP_LLI: begin
				payload.write_kind = WRITE_LOWER;
				payload.select_immediate = 1'b1;
				is_exec = 1'b1;
			end
			OP_LUI: begin
				payload.write_kind = WRITE_UPPER;
				payload.select_immediate = 1'b1;
				is_exec = 1'b1;
			end
			OP_B: begin
				is_branch = 1'b1;
			end
			OP_BL: begin
				is_branch = 1'b1;
				is_link = 1'b1;
			end
			OP_RET: begin
				is_return = 1'b1;
			end
			default: begin
				is_exec = 1'b0;
			end
		endcase

		case (opcode)
			OP_SUB: payload.alu_op = ALU_SUB;
			OP_AND, OP_ANDI: payload.alu_op = ALU_AND;
			OP_OR, OP_ORI: payload.alu_op = ALU_OR;
			OP_XOR: payload.alu_op = ALU_XOR;
			OP_SLL: payload.alu_op = ALU_SLL;
			OP_SRL: payload.alu_op = ALU_SRL;
			OP_SRA: payload.alu_op = ALU_SRA;
			default: payload.alu_op = ALU_ADD;
		endcase

		// r0 writes cancelled here, flags still update
		if (payload.dest == '0) begin
			payload.write_kind = WRITE_NONE;
		end
	end

	assign payload_bubble = fetched_bubble || !is_exec;

	////////////////////////////////////////////////////////////////////////////
	// branch resolution and hazards
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (cond)
			COND_NE: condition_met = !flags.zero;
			COND_EQ: condition_met = flags.zero;
			COND_GT: condition_met = !flags.zero && !flags.sign;
			COND_LT: condition_met = !flags.zero && flags.sign;
			COND_GE: condition_met = flags.zero || !flags.sign;
			COND_LE: condition_met = flags.zero || flags.sign;
			COND_OVERFLOW: condition_met = flags.overflow;
			default: condition_met = 1'b1;
		endcase
	end

	assign hazard_read =
		(reads_src1 && (half_pending(pending_ex, rf_addr1) || half_pending(pending_wb, rf_addr1)))
		|| (reads_src2 && (half_pending(pending_ex, rf_addr2)
		|| half_pending(pending_wb, rf_addr2)));
	// flags not yet written by the op in execute
	assign hazard_branch = is_branch && flag_update_pending;
	assign stall = !fetched_bubble && (hazard_read || hazard_branch);

	assign link_value = fetched_pc + 1'b1;
	assign branch_target = link_value + immediate[INSTR_ADDR_WIDTH-1:0];
	assign branch_taken = is_branch && condition_met && !stall;
	assign link_write = branch_taken && is_link;
	assign link_return = is_return && !stall;

endmodule

`default_nettype wire

//--- rtl/register_file.sv
`default_nettype none
`timescale 1ns/1ns

module register_file (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire isa_pkg::reg_addr_t    addr1,
	input  wire isa_pkg::reg_addr_t    addr2,
	output isa_pkg::word_t             data1,
	output isa_pkg::word_t             data2,
	input  wire pipe_pkg::reg_write_t  write
);

	import isa_pkg::*;
	import pipe_pkg::*;

	word_t regs [32];
	word_t write_value;
	logic writing;

	// r0 is never written so it reads as zero
	assign writing = (write.write_kind != WRITE_NONE) && (write.dest != '0);

	// new contents of the target register, half writes take the low data half
	always_comb begin
		case (write.write_kind)
			WRITE_LOWER: write_value = {regs[write.dest][31:16], write.data[15:0]};
			WRITE_UPPER: write_value = {write.data[15:0], regs[write.dest][15:0]};
			default: write_value = write.data;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (writing) begin
			regs[write.dest] <= write_value;
		end
	end

	// write-through
	assign data1 = (writing && write.dest == addr1) ? write_value : regs[addr1];
	assign data2 = (writing && write.dest == addr2) ? write_value : regs[addr2];

endmodule

`default_nettype wire

//--- rtl/stage_reg.sv
`default_nettype none
`timescale 1ns/1ns

module stage_reg #(
	parameter type payload_t = logic [31:0]
) (
	input  wire            clk,
	input  wire            rst_n,
	input  wire            insert_bubble,
	input  wire payload_t  d,
	input  wire            d_bubble,
	output payload_t       q,
	output logic           q_bubble
);

	// an all-zero payload has write kind none
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			q <= '0;
			q_bubble <= 1'b1;
		end else if (insert_bubble || d_bubble) begin
			q <= '0;
			q_bubble <= 1'b1;
		end else begin
			q <= d;
			q_bubble <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- rtl/execute_unit.sv
`default_nettype none
`timescale 1ns/1ns

module execute_unit (
	input  wire                         clk,
	input  wire                         rst_n,
	input  wire pipe_pkg::ex_payload_t  payload,
	input  wire                         payload_bubble,
	input  wire pipe_pkg::reg_write_t   forward,
	output pipe_pkg::wb_payload_t       result,
	output isa_pkg::flags_t             flags,
	output logic                        flag_update_pending
);

	import isa_pkg::*;
	import pipe_pkg::*;

	word_t op1;
	word_t op2;
	word_t alu_out;
	logic overflow;
	flags_t next_flags;

	////////////////////////////////////////////////////////////////////////////
	// operand selection
	////////////////////////////////////////////////////////////////////////////

	// only full writes forward, half writes stall in decode
	assign op1 = (forward.write_kind == WRITE_FULL && forward.dest == payload.source1)
		? forward.data : payload.operand1;

	always_comb begin
		if (payload.use_immediate) begin
			op2 = payload.immediate;
		end else if (forward.write_kind == WRITE_FULL && forward.dest == payload.source2) begin
			op2 = forward.data;
		end else begin
			op2 = payload.operand2;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// ALU
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (payload.alu_op)
			ALU_ADD: alu_out = op1 + op2;
			ALU_SUB: alu_out = op1 - op2;
			ALU_AND: alu_out = op1 & op2;
			ALU_OR: alu_out = op1 | op2;
			ALU_XOR: alu_out = op1 ^ op2;
			ALU_SLL: alu_out = op1 << op2[4:0];
			ALU_SRL: alu_out = op1 >> op2[4:0];
			default: alu_out = word_t'($signed(op1) >>> op2[4:0]);
		endcase
	end

	// signed overflow
	always_comb begin
		case (payload.alu_op)
			ALU_ADD: overflow = (op1[31] == op2[31]) && (alu_out[31] != op1[31]);
			ALU_SUB: overflow = (op1[31] != op2[31]) && (alu_out[31] != op1[31]);
			default: overflow = 1'b0;
		endcase
	end

	always_comb begin
		result.write_kind = payload_bubble ? WRITE_NONE : payload.write_kind;
		result.dest = payload.dest;
		// lli / lui carry the sign-extended immediate
		result.data = payload.select_immediate ? payload.immediate : alu_out;
	end

	// flags register
	assign next_flags = '{zero: (alu_out == '0), sign: alu_out[31], overflow: overflow};
	assign flag_update_pending = payload.update_flags && !payload_bubble;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			flags <= '0;
		end else if (flag_update_pending) begin
			flags <= next_flags;
		end
	end

endmodule

`default_nettype wire

//--- rtl/pipeline_core.sv
`default_nettype none
`timescale 1ns/1ns

module pipeline_core #(
	parameter int INSTR_ADDR_WIDTH = 11
) (
	input  wire                          clk,
	input  wire                          rst_n,
	output logic [INSTR_ADDR_WIDTH-1:0]  instr_addr,
	input  wire isa_pkg::word_t          instr,
	output pipe_pkg::reg_write_t         reg_write
);

	import isa_pkg::*;
	import pipe_pkg::*;

	// fetch / decode
	word_t fetched_instr;
	logic [INSTR_ADDR_WIDTH-1:0] fetched_pc;
	logic fetched_bubble;
	logic stall;
	logic branch_taken;
	logic [INSTR_ADDR_WIDTH-1:0] branch_target;
	logic link_write;
	logic [INSTR_ADDR_WIDTH-1:0] link_value;
	logic link_return;

	// register file read ports
	reg_addr_t rf_addr1;
	reg_addr_t rf_addr2;
	word_t rf_data1;
	word_t rf_data2;

	// decode / execute
	ex_payload_t id_payload;
	logic id_bubble;
	ex_payload_t ex_payload;
	logic ex_bubble;
	wb_payload_t ex_result;
	flags_t flags;
	logic flag_update_pending;

	////////////////////////////////////////////////////////////////////////////
	// stages
	////////////////////////////////////////////////////////////////////////////

	fetch_unit #(
		.INSTR_ADDR_WIDTH(INSTR_ADDR_WIDTH)
	) u_fetch (
		.clk(clk),
		.rst_n(rst_n),
		.instr(instr),
		.stall(stall),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.link_write(link_write),
		.link_value(link_value),
		.link_return(link_return),
		.instr_addr(instr_addr),
		.fetched_instr(fetched_instr),
		.fetched_pc(fetched_pc),
		.fetched_bubble(fetched_bubble)
	);

	decode_unit #(
		.INSTR_ADDR_WIDTH(INSTR_ADDR_WIDTH)
	) u_decode (
		.fetched_instr(fetched_instr),
		.fetched_pc(fetched_pc),
		.fetched_bubble(fetched_bubble),
		.flags(flags),
		.flag_update_pending(flag_update_pending),
		.pending_ex(ex_result),
		.pending_wb(reg_write),
		.rf_addr1(rf_addr1),
		.rf_addr2(rf_addr2),
		.rf_data1(rf_data1),
		.rf_data2(rf_data2),
		.payload(id_payload),
		.payload_bubble(id_bubble),
		.stall(stall),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.link_write(link_write),
		.link_value(link_value),
		.link_return(link_return)
	);

	register_file u_regs (
		.clk(clk),
		.rst_n(rst_n),
		.addr1(rf_addr1),
		.addr2(rf_addr2),
		.data1(rf_data1),
		.data2(rf_data2),
		.write(reg_write)
	);

	// a decode stall sends a bubble into execute
	stage_reg #(
		.payload_t(ex_payload_t)
	) u_id_ex (
		.clk(clk),
		.rst_n(rst_n),
		.insert_bubble(stall),
		.d(id_payload),
		.d_bubble(id_bubble),
		.q(ex_payload),
		.q_bubble(ex_bubble)
	);

	execute_unit u_execute (
		.clk(clk),
		.rst_n(rst_n),
		.payload(ex_payload),
		.payload_bubble(ex_bubble),
		.forward(reg_write),
		.result(ex_result),
		.flags(flags),
		.flag_update_pending(flag_update_pending)
	);

	// execute and writeback never stall
	stage_reg #(
		.payload_t(wb_payload_t)
	) u_ex_wb (
		.clk(clk),
		.rst_n(rst_n),
		.insert_bubble(1'b0),
		.d(ex_result),
		.d_bubble(ex_bubble),
		.q(reg_write),
		.q_bubble()
	);

endmodule

`default_nettype wire

//--- verif/pipeline_core_sva.sv
`default_nettype none
`timescale 1ns/1ns

module pipeline_core_sva #(
	parameter int INSTR_ADDR_WIDTH = 11
) (
	input wire                         clk,
	input wire                         rst_n,
	input wire [INSTR_ADDR_WIDTH-1:0]  instr_addr,
	input wire pipe_pkg::reg_write_t   reg_write,
	input wire                         branch_taken,
	input wire                         link_return
);

	import pipe_pkg::*;

	// r0 writes are cancelled in decode
	no_r0_write: assert property (@(posedge clk) disable iff (!rst_n)
		reg_write.write_kind != WRITE_NONE |-> reg_write.dest != '0)
		else $error("register write reaches r0");

	quiet_in_reset: assert property (@(posedge clk)
		!rst_n |-> reg_write.write_kind == WRITE_NONE)
		else $error("register write during reset");

	// sequential fetch holds or steps by one
	pc_step: assert property (@(posedge clk) disable iff (!rst_n)
		!branch_taken && !link_return |=> instr_addr == $past(instr_addr)
			|| instr_addr == INSTR_ADDR_WIDTH'($past(instr_addr) + 1'b1))
		else $error("fetch address jumped without a branch or return");

endmodule

bind pipeline_core pipeline_core_sva #(
	.INSTR_ADDR_WIDTH(INSTR_ADDR_WIDTH)
) u_sva (
	.clk(clk),
	.rst_n(rst_n),
	.instr_addr(instr_addr),
	.reg_write(reg_write),
	.branch_taken(branch_taken),
	.link_return(link_return)
);

`default_nettype wire

//--- verif/pipeline_core_tb.sv
`default_nettype none
`timescale 1ns/1ns

module pipeline_core_tb;

	import isa_pkg::*;
	import pipe_pkg::*;

	localparam int ADDR_WIDTH = 11;
	localparam int MEM_DEPTH = 2 ** ADDR_WIDTH;

	logic clk;
	logic rst_n;
	logic [ADDR_WIDTH-1:0] instr_addr;
	word_t instr;
	reg_write_t reg_write;

	word_t program_mem [MEM_DEPTH];
	int prog_len;
	string test_name;

	reg_write_t expected_q [$];
	reg_write_t seen_q [$];
	logic collecting;

	logic [31:0] lfsr = 32'hb69101c8;
	int cycle_count = 0;
	int cycle_limit = 0;
	int check_count = 0;
	int value_errors = 0;
	int other_errors = 0;

	pipeline_core #(
		.INSTR_ADDR_WIDTH(ADDR_WIDTH)
	) UUT (
		.clk(clk),
		.rst_n(rst_n),
		.instr_addr(instr_addr),
		.instr(instr),
		.reg_write(reg_write)
	);

	// instruction memory answers in the same cycle
	assign instr = program_mem[instr_addr];

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// watchdog
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			$display("timeout: run still going after %0d cycles", cycle_count);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// writeback monitor samples mid-cycle
	always @(negedge clk) begin
		if (collecting && reg_write.write_kind != WRITE_NONE) begin
			seen_q.push_back(reg_write);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// instruction encoding and program building
	////////////////////////////////////////////////////////////////////////////

	function automatic word_t reg_instr(opcode_e op, int d, int s1, int s2);
		return {op, d[4:0], s1[4:0], s2[4:0], 12'h000};
	endfunction

	function automatic word_t imm_instr(opcode_e op, int d, int s1, int imm);
		return {op, d[4:0], s1[4:0], 1'b0, imm[15:0]};
	endfunction

	// condition sits in the top three dest bits
	function automatic word_t branch_instr(opcode_e op, int cond, int offset);
		return {op, cond[2:0], 2'b00, 5'b00000, 1'b0, offset[15:0]};
	endfunction

	function automatic word_t return_instr();
		return {OP_RET, 27'h0};
	endfunction

	function automatic void emit(word_t w);
		program_mem[prog_len] = w;
		prog_len++;
	endfunction

	function automatic void load_word(int r, word_t value);
		emit(imm_instr(OP_LUI, r, 0, int'(value[31:16])));
		emit(imm_instr(OP_LLI, r, 0, int'(value[15:0])));
	endfunction

	function automatic void clear_program();
		for (int i = 0; i < MEM_DEPTH; i++) begin
			program_mem[i] = '0;
		end
		prog_len = 0;
	endfunction

	// fibonacci LFSR with taps 32 22 2 1 stepped once per bit
	function automatic word_t random_bits(int count);
		word_t value;
		logic feedback;
		value = '0;
		for (int i = 0; i < count; i++) begin
			feedback = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], feedback};
			value = {value[30:0], feedback};
		end
		return value;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// sequential ISA model
	////////////////////////////////////////////////////////////////////////////

	function automatic logic condition_holds(flags_t f, logic [2:0] cond);
		case (branch_cond_e'(cond))
			COND_NE: return !f.zero;
			COND_EQ: return f.zero;
			COND_GT: return !f.zero && !f.sign;
			COND_LT: return !f.zero && f.sign;
			COND_GE: return f.zero || !f.sign;
			COND_LE: return f.zero || f.sign;
			COND_OVERFLOW: return f.overflow;
			default: return 1'b1;
		endcase
	endfunction

	function automatic void push_expected(write_kind_e kind, reg_addr_t dest, word_t data);
		reg_write_t w;
		w.write_kind = kind;
		w.dest = dest;
		w.data = data;
		expected_q.push_back(w);
	endfunction

	task automatic run_model();
		word_t regs [32];
		flags_t fl;
		word_t ins;
		word_t a;
		word_t b;
		word_t imm;
		word_t res;
		reg_addr_t dest;
		opcode_e op;
		longint wide;
		logic alu;
		logic arith;
		int pc;
		int link;
		int steps;

		expected_q.delete();
		for (int i = 0; i < 32; i++) begin
			regs[i] = '0;
		end
		fl = '0;
		pc = 0;
		link = 0;
		steps = 0;
		while (pc < prog_len && steps < 10000) begin
			ins = program_mem[pc];
			op = opcode_e'(ins[OPCODE_MSB:OPCODE_LSB]);
			dest = ins[DEST_MSB:DEST_LSB];
			imm = {{16{ins[15]}}, ins[15:0]};
			a = regs[ins[SRC1_MSB:SRC1_LSB]];
			b = regs[ins[SRC2_MSB:SRC2_LSB]];
			if (op inside {OP_ADDI, OP_ANDI, OP_ORI}) begin
				b = imm;
			end
			pc++;
			steps++;

			case (op)
				OP_ADD, OP_ADDI: res = a + b;
				OP_SUB: res = a - b;
				OP_AND, OP_ANDI: res = a & b;
				OP_OR, OP_ORI: res = a | b;
				OP_XOR: res = a ^ b;
				OP_SLL: res = a << b[4:0];
				OP_SRL: res = a >> b[4:0];
				// logical shift with the vacated top bits filled from the sign
				OP_SRA: res = (a >> b[4:0]) | ({32{a[31]}} & ~(32'hffff_ffff >> b[4:0]));
				default: res = '0;
			endcase
			if (op == OP_SUB) begin
				wide = longint'($signed(a)) - longint'($signed(b));
			end else begin
				wide = longint'($signed(a)) + longint'($signed(b));
			end
			// the all-zero word decodes as add but is a bubble
			alu = (ins != '0) && (op inside {OP_ADD, OP_ADDI, OP_SUB, OP_AND, OP_ANDI,
				OP_OR, OP_ORI, OP_XOR, OP_SLL, OP_SRL, OP_SRA});
			arith = op inside {OP_ADD, OP_ADDI, OP_SUB};

			if (alu) begin
				fl.zero = (res == '0);
				fl.sign = res[31];
				fl.overflow = arith && (wide != longint'($signed(res)));
				if (dest != '0) begin
					regs[dest] = res;
					push_expected(WRITE_FULL, dest, res);
				end
			end else if (op == OP_LLI && dest != '0) begin
				regs[dest][15:0] = imm[15:0];
				push_expected(WRITE_LOWER, dest, imm);
			end else if (op == OP_LUI && dest != '0) begin
				regs[dest][31:16] = imm[15:0];
				push_expected(WRITE_UPPER, dest, imm);
			end else if ((op == OP_B || op == OP_BL) && condition_holds(fl, ins[DEST_MSB -: 3])) begin
				if (op == OP_BL) begin
					link = pc;
				end
				pc = pc + int'($signed(imm));
			end else if (op == OP_RET) begin
				pc = link;
			end
		end
		if (steps >= 10000) begin
			other_errors++;
			$display("%s: reference model never reached the end of the program", test_name);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_word(string name, word_t got, word_t expected);
		check_count++;
		if (got !== expected) begin
			value_errors++;
			$display("ERROR %0t %s got %h expected %h", $time, name, got, expected);
		end
	endtask

	task automatic check_reg(string name, reg_addr_t got, reg_addr_t expected);
		check_count++;
		if (got !== expected) begin
			value_errors++;
			$display("ERROR %0t %s got r%0d expected r%0d", $time, name, got, expected);
		end
	endtask

	task automatic check_kind(string name, write_kind_e got, write_kind_e expected);
		check_count++;
		if (got !== expected) begin
			value_errors++;
			$display("ERROR %0t %s got %s expected %s", $time, name, got.name(),
				expected.name());
		end
	endtask

	task automatic compare_writes();
		int n;
		n = (seen_q.size() < expected_q.size()) ? seen_q.size() : expected_q.size();
		for (int i = 0; i < n; i++) begin
			check_kind($sformatf("reg_write.write_kind (%s, write %0d)", test_name, i),
				seen_q[i].write_kind, expected_q[i].write_kind);
			check_reg($sformatf("reg_write.dest (%s, write %0d)", test_name, i),
				seen_q[i].dest, expected_q[i].dest);
			check_word($sformatf("reg_write.data (%s, write %0d)", test_name, i),
				seen_q[i].data, expected_q[i].data);
		end
		if (seen_q.size() < expected_q.size()) begin
			other_errors++;
			$display("%s: %0d expected register writes never appeared", test_name,
				expected_q.size() - seen_q.size());
		end else if (seen_q.size() > expected_q.size()) begin
			other_errors++;
			$display("%s: %0d register writes appeared that the program should not make",
				test_name, seen_q.size() - expected_q.size());
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// test sequencing
	////////////////////////////////////////////////////////////////////////////

	// core held in reset while the program is written
	task automatic begin_test(string name);
		cycle_limit += 20;
		test_name = name;
		@(posedge clk);
		#5;
		rst_n = 1'b0;
		clear_program();
	endtask

	task automatic run_program();
		run_model();
		cycle_limit += prog_len * 4;
		repeat (10) @(posedge clk);
		#5;
		seen_q.delete();
		collecting = 1'b1;
		rst_n = 1'b1;
		// run until fetch is past the end and the pipeline has drained
		while (int'(instr_addr) < prog_len + 4) begin
			@(posedge clk);
			#5;
		end
		collecting = 1'b0;
		compare_writes();
	endtask

	task automatic alu_and_shift_ops();
		begin_test("alu ops");
		load_word(1, 32'h8000_1234);
		// shift amount 37 masks to 5
		emit(imm_instr(OP_LLI, 2, 0, 16'h0025));
		emit(imm_instr(OP_ADDI, 3, 0, 3));
		emit(reg_instr(OP_ADD, 4, 1, 2));
		emit(reg_instr(OP_SUB, 5, 1, 2));
		emit(reg_instr(OP_AND, 6, 1, 2));
		emit(reg_instr(OP_OR, 7, 1, 2));
		emit(reg_instr(OP_XOR, 8, 1, 2));
		emit(reg_instr(OP_SLL, 9, 1, 2));
		emit(reg_instr(OP_SRL, 10, 1, 2));
		emit(reg_instr(OP_SRA, 11, 1, 2));
		emit(reg_instr(OP_SRA, 12, 1, 3));
		emit(reg_instr(OP_SRL, 13, 1, 3));
		emit(imm_instr(OP_ADDI, 14, 1, -5));
		emit(imm_instr(OP_ANDI, 15, 1, 16'h0ff0));
		emit(imm_instr(OP_ORI, 16, 1, 16'h8001));
		emit(imm_instr(OP_ADDI, 17, 2, -100));
		run_program();
	endtask

	task automatic dependent_chain();
		begin_test("forwarding");
		emit(imm_instr(OP_ADDI, 1, 0, 5));
		emit(imm_instr(OP_ADDI, 1, 1, 7));
		emit(reg_instr(OP_ADD, 2, 1, 1));
		emit(reg_instr(OP_SUB, 3, 2, 1));
		emit(imm_instr(OP_ADDI, 0, 1, 9));
		emit(reg_instr(OP_ADD, 4, 0, 2));
		// dropped peripheral opcode with dest r8 runs as a bubble
		emit({5'b10100, 27'h2123456});
		emit(reg_instr(OP_XOR, 5, 4, 3));
		emit(reg_instr(OP_OR, 6, 5, 4));
		emit(reg_instr(OP_SLL, 7, 6, 1));
		run_program();
	endtask

	task automatic half_write_pair();
		begin_test("half writes");
		emit(imm_instr(OP_LUI, 7, 0, 16'hdead));
		emit(imm_instr(OP_LLI, 7, 0, 16'hbeef));
		emit(imm_instr(OP_ADDI, 8, 7, 1));
		emit(reg_instr(OP_ADD, 9, 7, 8));
		emit(imm_instr(OP_LLI, 9, 0, 16'h0042));
		emit(reg_instr(OP_SRL, 10, 9, 8));
		run_program();
	endtask

	task automatic branch_conditions();
		int marker;
		begin_test("branch conditions");
		emit(imm_instr(OP_ADDI, 1, 0, 5));
		emit(imm_instr(OP_LUI, 2, 0, 16'h4000));
		for (int state = 0; state < 4; state++) begin
			for (int cond = 0; cond < 8; cond++) begin
				// zero, negative, positive, then signed overflow
				case (state)
					0: emit(reg_instr(OP_SUB, 0, 1, 1));
					1: emit(reg_instr(OP_SUB, 0, 0, 1));
					2: emit(reg_instr(OP_SUB, 0, 1, 0));
					default: emit(reg_instr(OP_ADD, 0, 2, 2));
				endcase
				emit(branch_instr(OP_B, cond, 1));
				marker = state * 8 + cond + 1;
				emit(imm_instr(OP_ADDI, 10, 0, marker));
			end
		end
		run_program();
	endtask

	task automatic call_and_return();
		begin_test("call and return");
		emit(imm_instr(OP_ADDI, 1, 0, 1));
		emit(branch_instr(OP_BL, 7, 3));
		emit(imm_instr(OP_ADDI, 2, 0, 2));
		emit(branch_instr(OP_B, 7, 3));
		emit(imm_instr(OP_ADDI, 3, 0, 3));
		// subroutine
		emit(imm_instr(OP_ADDI, 4, 0, 4));
		emit(return_instr());
		emit(imm_instr(OP_ADDI, 5, 0, 5));
		emit(reg_instr(OP_ADD, 6, 1, 4));
		run_program();
	endtask

	task automatic random_arith();
		int kind;
		int d;
		int s1;
		int s2;
		begin_test("random ops");
		for (int r = 1; r <= 8; r++) begin
			load_word(r, random_bits(32));
		end
		for (int i = 0; i < 20; i++) begin
			kind = int'(random_bits(2));
			d = 1 + int'(random_bits(3));
			s1 = 1 + int'(random_bits(3));
			s2 = 1 + int'(random_bits(3));
			case (kind)
				0: emit(reg_instr(OP_ADD, d, s1, s2));
				1: emit(reg_instr(OP_SUB, d, s1, s2));
				2: emit(reg_instr(OP_XOR, d, s1, s2));
				default: emit(imm_instr(OP_ORI, d, s1, int'(random_bits(16))));
			endcase
		end
		run_program();
	endtask

	initial begin
		rst_n = 1'b0;
		collecting = 1'b0;
		test_name = "";
		clear_program();

		alu_and_shift_ops();
		dependent_chain();
		half_write_pair();
		branch_conditions();
		call_and_return();
		random_arith();

		$display("checks %0d, value errors %0d, other errors %0d", check_count,
			value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- pipeline_core.f
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/fetch_unit.sv
rtl/decode_unit.sv
rtl/register_file.sv
rtl/stage_reg.sv
rtl/execute_unit.sv
rtl/pipeline_core.sv
verif/pipeline_core_sva.sv
verif/pipeline_core_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = pipeline_core_tb
FILELIST = pipeline_core.f
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	! grep -q "CHECKS FAILED" $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
